// ==== Bender.yml ====
package:
  name: keypad_lock

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lock_pkg.sv
      - hdl/tone_pkg.sv
      - hdl/key_decoder.sv
      - hdl/entry_controller.sv
      - hdl/lockout_timer.sv
      - hdl/buzzer_driver.sv
      - hdl/keypad_lock.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock.sv
      - tests/keypad_lock_sva.sv
      - tests/keypad_lock_tb.sv

// ==== compile.f ====
+incdir+hdl
hdl/lock_pkg.sv
hdl/tone_pkg.sv
hdl/key_decoder.sv
hdl/entry_controller.sv
hdl/lockout_timer.sv
hdl/buzzer_driver.sv
hdl/keypad_lock.sv
tests/tb_clock.sv
tests/keypad_lock_sva.sv
tests/keypad_lock_tb.sv

// ==== hdl/buzzer_driver.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lock_macros.svh"

module buzzer_driver import tone_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  tone_req,
    input  tone_t tone_sel,
    output logic  buzzer
);

    tone_t       pattern;  // tone playing now
    logic [15:0] dur_cnt;  // cycles since tone start
    logic [15:0] half_cnt;
    logic        phase;
    logic [15:0] half_lim;
    logic [15:0] dur_lim;
    logic        in_gap;

    always_comb begin
        case (pattern)
            tone_click: begin
                half_lim = 16'(`CLICK_HALF_PERIOD);
                dur_lim  = 16'(`CLICK_CYCLES);
            end
            tone_ok: begin
                half_lim = 16'(`OK_HALF_PERIOD);
                dur_lim  = 16'(`OK_CYCLES);
            end
            tone_fail: begin
                half_lim = 16'(`FAIL_HALF_PERIOD);
                dur_lim  = 16'(`FAIL_CYCLES);
            end
            default: begin
                half_lim = 16'd1;
                dur_lim  = 16'd1;
            end
        endcase
    end

    // broken low tone that is silent in the middle
    assign in_gap = (pattern == tone_fail) &&
                    (dur_cnt >= 16'(`FAIL_GAP_START)) && (dur_cnt < 16'(`FAIL_GAP_END));

    always_ff @(posedge clk) begin
        if (reset) begin
            pattern  <= tone_none;
            dur_cnt  <= 16'd0;
            half_cnt <= 16'd0;
            phase    <= 1'b0;
            buzzer   <= 1'b0;
        end else if (tone_req) begin // latest request restarts
            pattern  <= tone_sel;
            dur_cnt  <= 16'd0;
            half_cnt <= 16'd0;
            phase    <= (tone_sel != tone_none);
            buzzer   <= (tone_sel != tone_none);
        end else if (pattern != tone_none) begin
            if (dur_cnt == dur_lim - 16'd1) begin
                pattern <= tone_none; // tone over
                phase   <= 1'b0;
                buzzer  <= 1'b0;
            end else begin
                dur_cnt <= dur_cnt + 16'd1;
                if (half_cnt == half_lim - 16'd1) begin
                    half_cnt <= 16'd0;
                    phase    <= ~phase;
                    buzzer   <= ~phase && !in_gap;
                end else begin
                    half_cnt <= half_cnt + 16'd1;
                    buzzer   <= phase && !in_gap;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/entry_controller.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lock_macros.svh"

module entry_controller import lock_pkg::*, tone_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        key_event,
    input  key_op_t     key_op,
    input  logic [3:0]  key_digit,
    input  logic        lock_done,
    input  logic [7:0]  lock_secs,
    output logic [11:0] display,
    output logic [2:0]  tries,
    output logic        open,
    output logic        locked,
    output logic        lock_start,
    output logic        tone_req,
    output tone_t       tone_sel
);

    entry_state_t state;
    logic [1:0]   digits; // digits entered so far
    logic [2:0]   tries_inc;

    assign tries_inc = tries + 3'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_entry;
            display    <= `BLANK_CODE;
            digits     <= 2'd0;
            tries      <= 3'd0;
            open       <= 1'b0;
            locked     <= 1'b0;
            lock_start <= 1'b0;
            tone_req   <= 1'b0;
            tone_sel   <= tone_none;
        end else begin
            lock_start <= 1'b0;
            tone_req   <= 1'b0;
            case (state)
                st_entry: begin
                    if (key_event) begin
                        case (key_op)
                            lock_pkg::key_digit: begin
                                if (digits < 2'd3) begin
                                    display <= {display[7:0], key_digit}; // shift left
                                    digits  <= digits + 2'd1;
                                end
                                tone_req <= 1'b1; // click even when full
                                tone_sel <= tone_click;
                            end
                            key_enter: begin
                                if (digits == 2'd3) begin
                                    tone_req <= 1'b1;
                                    if (display == `PASS_CODE) begin
                                        state    <= st_open;
                                        display  <= `OPEN_CODE;
                                        open     <= 1'b1;
                                        tone_sel <= tone_ok;
                                    end else begin
                                        display  <= `BLANK_CODE;
                                        digits   <= 2'd0;
                                        tries    <= tries_inc;
                                        tone_sel <= tone_fail;
                                        if (tries_inc == 3'(`MAX_TRIES)) begin
                                            state      <= st_locked;
                                            locked     <= 1'b1;
                                            lock_start <= 1'b1;
                                            display    <= 12'h000; // count starts at zero
                                        end
                                    end
                                end
                            end
                            key_clear: begin
                                display <= `BLANK_CODE;
                                digits  <= 2'd0;
                                tries   <= 3'd0;
                            end
                            default: begin // cancel
                                display <= `BLANK_CODE;
                                digits  <= 2'd0;
                            end
                        endcase
                    end
                end
                st_open: begin
                    if (key_event && (key_op == key_clear || key_op == key_cancel)) begin
                        state   <= st_entry;
                        display <= `BLANK_CODE;
                        digits  <= 2'd0;
                        open    <= 1'b0;
                        if (key_op == key_clear)
                            tries <= 3'd0;
                    end
                end
                st_locked: begin
                    // timer restarts one cycle after lock_start so the old count is still visible
                    if (lock_start)
                        display <= 12'h000;
                    else
                        display <= {4'h0, lock_secs};
                    if (lock_done) begin
                        state   <= st_entry;
                        display <= `BLANK_CODE;
                        digits  <= 2'd0;
                        tries   <= 3'd0;
                        locked  <= 1'b0;
                    end
                end
                default: begin
                    state <= st_entry;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/key_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_decoder import lock_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] onehot,
    output logic        key_event,
    output key_op_t     key_op,
    output logic [3:0]  key_digit
);

    logic [15:0] prev_word;
    logic        map_valid;
    key_op_t     map_op;
    logic [3:0]  map_digit;

    // key table
    always_comb begin
        map_valid = 1'b1;
        map_op    = lock_pkg::key_digit;
        map_digit = 4'd0;
        case (onehot)
            16'h0008: map_digit = 4'd0;
            16'h0080: map_digit = 4'd1;
            16'h0040: map_digit = 4'd2;
            16'h0020: map_digit = 4'd3;
            16'h0800: map_digit = 4'd4;
            16'h0400: map_digit = 4'd5;
            16'h0200: map_digit = 4'd6;
            16'h8000: map_digit = 4'd7;
            16'h4000: map_digit = 4'd8;
            16'h2000: map_digit = 4'd9;
            16'h0001: map_op    = key_enter;
            16'h0100: map_op    = key_clear;
            16'h1000: map_op    = key_cancel;
            default:  map_valid = 1'b0; // zero and unmapped codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_word <= 16'h0000;
            key_event <= 1'b0;
        end else begin
            prev_word <= onehot;
            key_event <= map_valid && (onehot != prev_word); // held key gives one event
        end
    end

    always_ff @(posedge clk) begin
        key_op    <= map_op;
        key_digit <= map_digit;
    end

endmodule

`default_nettype wire

// ==== hdl/keypad_lock.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypad_lock import lock_pkg::*, tone_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] onehot,
    output logic [11:0] display,
    output logic [2:0]  tries,
    output logic        open,
    output logic        locked,
    output logic        buzzer
);

    logic       key_event;
    key_op_t    key_op;
    logic [3:0] key_digit;
    logic       lock_start;
    logic       lock_done;
    logic [7:0] lock_secs;
    logic       tone_req;
    tone_t      tone_sel;

    key_decoder u_key_decoder (
        .clk       (clk),
        .reset     (reset),
        .onehot    (onehot),
        .key_event (key_event),
        .key_op    (key_op),
        .key_digit (key_digit)
    );

    entry_controller u_entry_controller (
        .clk        (clk),
        .reset      (reset),
        .key_event  (key_event),
        .key_op     (key_op),
        .key_digit  (key_digit),
        .lock_done  (lock_done),
        .lock_secs  (lock_secs),
        .display    (display),
        .tries      (tries),
        .open       (open),
        .locked     (locked),
        .lock_start (lock_start),
        .tone_req   (tone_req),
        .tone_sel   (tone_sel)
    );

    lockout_timer u_lockout_timer (
        .clk        (clk),
        .reset      (reset),
        .lock_start (lock_start),
        .lock_secs  (lock_secs),
        .lock_done  (lock_done)
    );

    buzzer_driver u_buzzer_driver (
        .clk      (clk),
        .reset    (reset),
        .tone_req (tone_req),
        .tone_sel (tone_sel),
        .buzzer   (buzzer)
    );

endmodule

`default_nettype wire

// ==== hdl/lock_macros.svh ====
`ifndef LOCK_MACROS_SVH
`define LOCK_MACROS_SVH

// password and display patterns in 12-bit BCD
`define PASS_CODE         12'h246
`define OPEN_CODE         12'hBCC
`define BLANK_CODE        12'hFFF

// failed tries before lockout
`define MAX_TRIES         4

// lockout length in seconds scaled for simulation
`define LOCKOUT_SECONDS   3
`define TICKS_PER_SECOND  50

// buzzer toggle intervals in clk cycles
`define CLICK_HALF_PERIOD 2
`define OK_HALF_PERIOD    3
`define FAIL_HALF_PERIOD  6

// buzzer tone lengths in clk cycles
`define CLICK_CYCLES      20
`define OK_CYCLES         60
`define FAIL_CYCLES       90

// silent window of the fail tone counted from tone start
`define FAIL_GAP_START    30
`define FAIL_GAP_END      60

`endif

// ==== hdl/lock_pkg.sv ====
`default_nettype none

package lock_pkg;

    // decoded key class
    typedef enum logic [1:0] {
        key_digit  = 2'd0,
        key_enter  = 2'd1,
        key_clear  = 2'd2,
        key_cancel = 2'd3
    } key_op_t;

    // lock FSM states
    typedef enum logic [1:0] {
        st_entry  = 2'd0, // collecting digits
        st_open   = 2'd1, // correct code shown
        st_locked = 2'd2  // too many failed tries
    } entry_state_t;

endpackage

`default_nettype wire

// ==== hdl/lockout_timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lock_macros.svh"

module lockout_timer (
    input  logic       clk,
    input  logic       reset,
    input  logic       lock_start,
    output logic [7:0] lock_secs,
    output logic       lock_done
);

    localparam int PRE_W = $clog2(`TICKS_PER_SECOND);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`TICKS_PER_SECOND - 1);
    localparam logic [7:0] DONE_BCD = {4'(`LOCKOUT_SECONDS / 10), 4'(`LOCKOUT_SECONDS % 10)};

    logic [PRE_W-1:0] prescale;
    logic             running;
    logic             tick;
    logic [7:0]       secs_next;

    assign tick = running && (prescale == PRE_LAST);

    // BCD increment with carry into tens
    always_comb begin
        secs_next = lock_secs;
        if (lock_secs[3:0] == 4'd9) begin
            secs_next[3:0] = 4'd0;
            secs_next[7:4] = (lock_secs[7:4] == 4'd9) ? 4'd0 : lock_secs[7:4] + 4'd1;
        end else begin
            secs_next[3:0] = lock_secs[3:0] + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale  <= '0;
            running   <= 1'b0;
            lock_secs <= 8'h00;
            lock_done <= 1'b0;
        end else begin
            lock_done <= 1'b0;
            if (lock_start) begin
                prescale  <= PRE_W'(1); // lock_start lags the lockout by one cycle
                running   <= 1'b1;
                lock_secs <= 8'h00;
            end else if (running) begin
                prescale <= tick ? '0 : prescale + PRE_W'(1);
                if (tick) begin
                    lock_secs <= secs_next;
                    if (secs_next == DONE_BCD) begin
                        running   <= 1'b0; // hold final count
                        lock_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tone_pkg.sv ====
`default_nettype none

package tone_pkg;

    // buzzer pattern select
    typedef enum logic [1:0] {
        tone_none  = 2'd0,
        tone_click = 2'd1, // short, one per digit
        tone_ok    = 2'd2, // long high tone
        tone_fail  = 2'd3  // low tone with a gap
    } tone_t;

endpackage

`default_nettype wire

// ==== tests/keypad_lock_sva.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lock_macros.svh"

module keypad_lock_sva (
    input logic       clk,
    input logic       reset,
    input logic       open,
    input logic       locked,
    input logic       buzzer,
    input logic       tone_req,
    input logic [2:0] tries
);

    logic [7:0] idle_cnt; // cycles since the last tone request

    always_ff @(posedge clk) begin
        if (reset || tone_req)
            idle_cnt <= 8'd0;
        else if (idle_cnt != 8'hff)
            idle_cnt <= idle_cnt + 8'd1; // saturate
    end

    open_locked_excl: assert property (@(posedge clk) disable iff (reset)
        !(open && locked))
        else $error("open and locked are high together");

    tries_bound: assert property (@(posedge clk) disable iff (reset)
        tries <= 3'(`MAX_TRIES))
        else $error("tries count is above the limit");

    // longest tone is the fail tone
    quiet_when_idle: assert property (@(posedge clk) disable iff (reset)
        (idle_cnt > 8'(`FAIL_CYCLES + 2)) |-> !buzzer)
        else $error("buzzer sounds with no tone playing");

endmodule

bind keypad_lock keypad_lock_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .open     (open),
    .locked   (locked),
    .buzzer   (buzzer),
    .tone_req (tone_req),
    .tries    (tries)
);

`default_nettype wire

// ==== tests/keypad_lock_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lock_macros.svh"

module keypad_lock_tb;

    typedef struct packed {
        logic [15:0] code;
        logic        release_key;
        logic        wait_unlock; // row waits for the lockout to end
        logic        disp_care;
        logic [11:0] disp;
        logic [2:0]  tries;
        logic        open;
        logic        locked;
    } row_t;

    logic        clk;
    logic        reset;
    logic [15:0] onehot;
    logic [11:0] display;
    logic [2:0]  tries;
    logic        open;
    logic        locked;
    logic        buzzer;

    row_t        rows[$];
    logic [11:0] m_disp; // reference model state
    int          m_digits;
    logic [2:0]  m_tries;
    bit          m_open;
    bit          m_locked;
    logic [15:0] m_prev;
    int          cycle_count;
    int          lock_cycle;
    bit          was_locked;
    logic [31:0] seed;
    row_t        cur;

    tb_clock u_clock (.clk(clk));

    keypad_lock uut (
        .clk     (clk),
        .reset   (reset),
        .onehot  (onehot),
        .display (display),
        .tries   (tries),
        .open    (open),
        .locked  (locked),
        .buzzer  (buzzer)
    );

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // index 0..9 for digits then enter, clear, cancel and unmapped codes
    function automatic logic [15:0] key_code(input int idx);
        case (idx)
            0:  return 16'h0008;
            1:  return 16'h0080;
            2:  return 16'h0040;
            3:  return 16'h0020;
            4:  return 16'h0800;
            5:  return 16'h0400;
            6:  return 16'h0200;
            7:  return 16'h8000;
            8:  return 16'h4000;
            9:  return 16'h2000;
            10: return 16'h0001;
            11: return 16'h0100;
            12: return 16'h1000;
            13: return 16'h0002;
            14: return 16'h0010;
            default: return 16'h0003; // two keys at once
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string name, input logic [15:0] exp_v,
                            input logic [15:0] act_v);
        $display("MISMATCH at %0d ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
        stop_run();
    endtask

    task automatic failure(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        stop_run();
    endtask

    // models one key row and appends the expected outputs
    task automatic add_key(input int idx, input bit rel);
        logic [15:0] code;
        bit          hit;
        bit          prior_locked;
        row_t        r;
        code = key_code(idx);
        hit = (idx < 13) && (code != m_prev); // held key gives no new event
        prior_locked = m_locked;
        m_prev = rel ? 16'h0000 : code;
        if (hit && m_open) begin
            if (idx == 11 || idx == 12) begin
                m_open = 1'b0;
                m_disp = `BLANK_CODE;
                m_digits = 0;
                if (idx == 11)
                    m_tries = 3'd0;
            end
        end else if (hit && !m_locked) begin
            if (idx < 10) begin
                if (m_digits < 3) begin
                    m_disp = {m_disp[7:0], 4'(idx)};
                    m_digits++;
                end
            end else if (idx == 10) begin
                if (m_digits == 3) begin
                    if (m_disp == `PASS_CODE) begin
                        m_open = 1'b1;
                        m_disp = `OPEN_CODE;
                    end else begin
                        m_disp = `BLANK_CODE;
                        m_digits = 0;
                        m_tries++;
                        if (m_tries == 3'(`MAX_TRIES)) begin
                            m_locked = 1'b1;
                            m_disp = 12'h000; // seconds count starts
                        end
                    end
                end
            end else begin
                m_disp = `BLANK_CODE;
                m_digits = 0;
                if (idx == 11)
                    m_tries = 3'd0;
            end
        end
        r.code = code;
        r.release_key = rel;
        r.wait_unlock = 1'b0;
        r.disp_care = !prior_locked; // count is checked by the lockout wait
        r.disp = m_disp;
        r.tries = m_tries;
        r.open = m_open;
        r.locked = m_locked;
        rows.push_back(r);
    endtask

    task automatic add_wait();
        row_t r;
        m_locked = 1'b0;
        m_disp = `BLANK_CODE;
        m_digits = 0;
        m_tries = 3'd0;
        r = '0;
        r.wait_unlock = 1'b1;
        r.disp_care = 1'b1;
        r.disp = `BLANK_CODE;
        rows.push_back(r);
    endtask

    task automatic check_outputs(input row_t r);
        if (r.disp_care)
            assert (display == r.disp) else mismatch("display", r.disp, display);
        assert (tries == r.tries) else mismatch("tries", r.tries, tries);
        assert (open == r.open) else mismatch("open", r.open, open);
        assert (locked == r.locked) else mismatch("locked", r.locked, locked);
    endtask

    task automatic wait_unlock();
        logic [11:0] last;
        last = 12'h000;
        while (locked) begin
            assert (cycle_count - lock_cycle <= `LOCKOUT_SECONDS * `TICKS_PER_SECOND + 4)
                else failure("lockout did not end in time");
            assert (display[11:4] == 8'h00 && int'(display[3:0]) < `LOCKOUT_SECONDS)
                else failure("display during lockout is not a valid seconds count");
            assert (display >= last) else failure("lockout seconds count went backwards");
            last = display;
            @(negedge clk);
        end
        assert (int'(last[3:0]) == `LOCKOUT_SECONDS - 1)
            else failure("lockout seconds count did not run through all seconds");
    endtask

    task automatic press(input logic [15:0] code);
        onehot = code;
        repeat (2) @(negedge clk);
        onehot = 16'h0000;
        @(negedge clk);
    endtask

    // silence longer than the fail gap
    task automatic wait_quiet();
        int run;
        int n;
        run = 0;
        n = 0;
        while (run < `FAIL_GAP_END - `FAIL_GAP_START + 2) begin
            assert (n < `FAIL_CYCLES + 40) else failure("buzzer did not fall silent");
            @(negedge clk);
            n++;
            run = buzzer ? 0 : run + 1;
        end
    endtask

    task automatic time_tone(input logic [15:0] code, input bit from_silence,
                             input int tone_len);
        int last_high;
        int i;
        onehot = code;
        repeat (2) @(negedge clk);
        if (from_silence)
            assert (buzzer == 1'b0) else mismatch("buzzer", 16'h0, buzzer);
        @(negedge clk);
        assert (buzzer == 1'b1) else mismatch("buzzer", 16'h1, buzzer); // 3 cycles after key
        onehot = 16'h0000;
        last_high = 0;
        for (i = 1; i < tone_len + 12; i++) begin
            @(negedge clk);
            if (buzzer)
                last_high = i;
        end
        assert (last_high < tone_len + 2) else failure("buzzer tone ran too long");
    endtask

    initial begin
        reset = 1'b1;
        onehot = 16'h0000;
        cycle_count = 0;
        lock_cycle = 0;
        was_locked = 1'b0;
        m_disp = `BLANK_CODE;
        m_digits = 0;
        m_tries = 3'd0;
        m_open = 1'b0;
        m_locked = 1'b0;
        m_prev = 16'h0000;

        // digit shift, full display, held key
        add_key(1, 1);
        add_key(2, 1);
        add_key(3, 1);
        add_key(4, 1);
        add_key(12, 1);
        add_key(7, 0);
        add_key(7, 1);
        // correct code
        add_key(12, 1);
        add_key(2, 1);
        add_key(4, 1);
        add_key(6, 1);
        add_key(10, 1);
        add_key(5, 1);
        add_key(11, 1);
        // wrong code, cancel, clear
        add_key(1, 1);
        add_key(1, 1);
        add_key(1, 1);
        add_key(10, 1);
        add_key(5, 1);
        add_key(5, 1);
        add_key(12, 1);
        add_key(11, 1);
        // lockout with keys ignored meanwhile
        for (int t = 0; t < `MAX_TRIES; t++) begin
            add_key(9, 1);
            add_key(8, 1);
            add_key(7, 1);
            add_key(10, 1);
        end
        add_key(1, 1);
        add_key(10, 1);
        add_key(11, 1);
        add_wait();
        // random keys including unmapped codes
        seed = 32'hb111;
        for (int k = 0; k < 40; k++) begin
            seed = lcg_next(seed);
            add_key(int'(seed[19:16]), seed[23]);
            if (m_locked) begin
                seed = lcg_next(seed);
                add_key(int'(seed[19:16]), 1'b1);
                add_wait();
            end
        end

        repeat (16) @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            cur = rows[i];
            if (cur.wait_unlock) begin
                wait_unlock();
                check_outputs(cur);
            end else begin
                onehot = cur.code;
                repeat (2) @(negedge clk);
                check_outputs(cur);
                if (cur.locked && !was_locked)
                    lock_cycle = cycle_count;
                if (cur.release_key)
                    onehot = 16'h0000;
                @(negedge clk);
            end
            was_locked = cur.locked;
        end

        // buzzer timing
        onehot = 16'h0000;
        @(negedge clk);
        press(key_code(11));
        wait_quiet();
        time_tone(key_code(1), 1'b1, `CLICK_CYCLES);
        press(key_code(1));
        press(key_code(1));
        time_tone(key_code(10), 1'b0, `FAIL_CYCLES);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

endmodule

`default_nettype wire
